//--- rtl/alu_core.sv
// Single-cycle ALU for all ops except divide and remainder, which return zero here
`timescale 1ns/1ps

module alu_core import alu_pkg::*; (
  input  alu_req_t req,
  output word_t    result,
  output logic     zero,
  output logic     negative,
  output logic     borrow
);

  logic [4:0]         shamt;
  logic signed [63:0] prod_ss;
  logic signed [63:0] prod_su;
  logic [63:0]        prod_uu;
  logic [32:0]        sub_u;

  assign shamt = req.b[4:0];  // RISC-V uses the low five bits only

  assign prod_ss = $signed(req.a) * $signed(req.b);
  assign prod_su = $signed(req.a) * $signed({1'b0, req.b});  // b kept non-negative
  assign prod_uu = req.a * req.b;
  assign sub_u   = {1'b0, req.a} - {1'b0, req.b};            // MSB is the borrow

  always_comb
  begin
    borrow = 1'b0;
    case (req.op)
      OP_AND:    result = req.a & req.b;
      OP_OR:     result = req.a | req.b;
      OP_ADD:    result = req.a + req.b;
      OP_XOR:    result = req.a ^ req.b;
      OP_SUB:    result = req.a - req.b;
      OP_NOT:    result = ~req.a;
      OP_SLL:    result = req.a << shamt;
      OP_SRL:    result = req.a >> shamt;
      OP_SRA:    result = $signed(req.a) >>> shamt;
      OP_SLT:
      begin
        result = {31'b0, $signed(req.a) < $signed(req.b)};
      end
      OP_SLTU:
      begin
        result = {31'b0, req.a < req.b};
      end
      OP_MUL:    result = prod_ss[31:0];   // Low half is sign independent
      OP_MULH:   result = prod_ss[63:32];
      OP_MULHSU: result = prod_su[63:32];
      OP_MULHU:  result = prod_uu[63:32];
      OP_SUBU:
      begin
        result = sub_u[31:0];
        borrow = sub_u[32];
      end
      default:   result = '0;              // Divider ops handled elsewhere
    endcase
  end

  assign zero     = (result == '0);
  assign negative = result[31];

endmodule

//--- rtl/alu_divider.sv
// Restoring divider taking 33 cycles from div_start to div_done; starts while busy are ignored
`timescale 1ns/1ps

module alu_divider import alu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  div_start,
  input  word_t dividend,
  input  word_t divisor,
  input  logic  is_signed,
  output logic  div_done,
  output word_t quotient,
  output word_t remainder
);

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_FIX
  } div_state_e;

  div_state_e  state;
  logic [4:0]  step;
  word_t       acc;      // Partial remainder
  word_t       quo;      // Dividend bits shifting out, quotient bits shifting in
  word_t       dvs;      // Divisor magnitude
  word_t       mag_a;
  word_t       mag_b;
  logic        neg_q;
  logic        neg_r;
  logic        by_zero;
  logic [32:0] shifted;
  logic [33:0] trial;

  assign mag_a = (is_signed && dividend[31]) ? -dividend : dividend;
  assign mag_b = (is_signed && divisor[31]) ? -divisor : divisor;

  assign shifted = {acc, quo[31]};
  assign trial   = {1'b0, shifted} - {2'b00, dvs};  // MSB set when divisor does not fit

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state <= DIV_IDLE;
      step  <= '0;
    end
    else
    begin
      case (state)
        DIV_IDLE:
        begin
          step <= '0;
          if (div_start)
            state <= DIV_RUN;
        end
        DIV_RUN:
        begin
          step <= step + 1'b1;
          if (step == 5'(DIV_STEPS - 1))
            state <= DIV_FIX;
        end
        default: state <= DIV_IDLE;  // Fix lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == DIV_IDLE && div_start)
    begin
      acc     <= '0;
      quo     <= mag_a;
      dvs     <= mag_b;
      neg_q   <= is_signed && (dividend[31] ^ divisor[31]);
      neg_r   <= is_signed && dividend[31];  // Remainder takes the dividend sign
      by_zero <= (divisor == '0);
    end
    else if (state == DIV_RUN)
    begin
      if (!trial[33])
      begin
        acc <= trial[31:0];
        quo <= {quo[30:0], 1'b1};
      end
      else
      begin
        acc <= shifted[31:0];
        quo <= {quo[30:0], 1'b0};
      end
    end
  end

  // Overflow case -2^31 / -1 lands on 0x80000000 rem 0 without special handling
  // Divide by zero leaves the dividend in acc, so only the quotient needs forcing
  assign div_done  = (state == DIV_FIX);
  assign quotient  = by_zero ? '1 : (neg_q ? -quo : quo);
  assign remainder = neg_r ? -acc : acc;

endmodule

//--- rtl/alu_exec_unit.sv
// Execute stage top; upstream must start with REQ_DEPTH credits and downstream with RSP_CREDITS
`timescale 1ns/1ps

module alu_exec_unit import alu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid,
  input  alu_req_t req,
  output logic     req_credit,
  output logic     rsp_valid,
  output alu_rsp_t rsp,
  input  logic     rsp_credit
);

  alu_req_t head;
  alu_req_t core_req;
  logic     head_valid;
  logic     pop;
  word_t    core_result;
  logic     core_zero;
  logic     core_negative;
  logic     core_borrow;
  logic     div_start;
  logic     is_signed;
  logic     div_done;
  word_t    dividend;
  word_t    divisor;
  word_t    quotient;
  word_t    remainder;

  alu_req_queue u_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .pop        (pop),
    .head       (head),
    .head_valid (head_valid),
    .req_credit (req_credit)
  );

  alu_issue u_issue (
    .clk           (clk),
    .rst_n         (rst_n),
    .head          (head),
    .head_valid    (head_valid),
    .pop           (pop),
    .core_req      (core_req),
    .core_result   (core_result),
    .core_zero     (core_zero),
    .core_negative (core_negative),
    .core_borrow   (core_borrow),
    .div_start     (div_start),
    .dividend      (dividend),
    .divisor       (divisor),
    .is_signed     (is_signed),
    .div_done      (div_done),
    .quotient      (quotient),
    .remainder     (remainder),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp),
    .rsp_credit    (rsp_credit)
  );

  alu_core u_core (
    .req      (core_req),
    .result   (core_result),
    .zero     (core_zero),
    .negative (core_negative),
    .borrow   (core_borrow)
  );

  alu_divider u_div (
    .clk       (clk),
    .rst_n     (rst_n),
    .div_start (div_start),
    .dividend  (dividend),
    .divisor   (divisor),
    .is_signed (is_signed),
    .div_done  (div_done),
    .quotient  (quotient),
    .remainder (remainder)
  );

endmodule

//--- rtl/alu_issue.sv
// In-order issue with one response in flight at a time; pops only when a response credit is free
`timescale 1ns/1ps

module alu_issue import alu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  alu_req_t head,
  input  logic     head_valid,
  output logic     pop,
  output alu_req_t core_req,
  input  word_t    core_result,
  input  logic     core_zero,
  input  logic     core_negative,
  input  logic     core_borrow,
  output logic     div_start,
  output word_t    dividend,
  output word_t    divisor,
  output logic     is_signed,
  input  logic     div_done,
  input  word_t    quotient,
  input  word_t    remainder,
  output logic     rsp_valid,
  output alu_rsp_t rsp,
  input  logic     rsp_credit
);

  typedef enum logic {
    ST_ACCEPT,
    ST_WAIT_DIV
  } issue_state_e;

  issue_state_e     state;
  alu_req_t         cur;              // Popped request
  logic             cur_valid;
  logic             cur_is_div;
  logic             head_is_div;
  logic             pending;          // A response is owed
  logic             div_rsp_valid;
  alu_rsp_t         div_rsp;
  alu_rsp_t         core_rsp;
  word_t            div_pick;
  logic [CNT_W-1:0] rsp_credit_cnt;

  function automatic logic op_is_div(alu_op_e op);
    return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  endfunction

  assign head_is_div = op_is_div(head.op);
  assign cur_is_div  = op_is_div(cur.op);
  assign pending     = cur_valid || div_rsp_valid;
  assign pop         = (state == ST_ACCEPT) && head_valid && (rsp_credit_cnt > CNT_W'(pending));

  assign core_req  = cur;
  assign dividend  = cur.a;
  assign divisor   = cur.b;
  assign is_signed = (cur.op == OP_DIV) || (cur.op == OP_REM);
  assign div_start = cur_valid && cur_is_div;
  assign div_pick  = (cur.op == OP_DIV || cur.op == OP_DIVU) ? quotient : remainder;

  always_comb
  begin
    core_rsp.result    = core_result;
    core_rsp.remainder = '0;
    core_rsp.zero      = core_zero;
    core_rsp.negative  = core_negative;
    core_rsp.borrow    = core_borrow;
    core_rsp.tag       = cur.tag;
  end

  // Both sources cannot be valid together since a divide blocks further pops
  assign rsp_valid = (cur_valid && !cur_is_div) || div_rsp_valid;
  assign rsp       = div_rsp_valid ? div_rsp : core_rsp;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state          <= ST_ACCEPT;
      cur_valid      <= 1'b0;
      div_rsp_valid  <= 1'b0;
      rsp_credit_cnt <= CNT_W'(RSP_CREDITS);
    end
    else
    begin
      cur_valid     <= pop;
      div_rsp_valid <= div_done;
      if (state == ST_ACCEPT && pop && head_is_div)
        state <= ST_WAIT_DIV;
      else if (state == ST_WAIT_DIV && div_done)
        state <= ST_ACCEPT;
      case ({rsp_valid, rsp_credit})
        2'b10:   rsp_credit_cnt <= rsp_credit_cnt - 1'b1;
        2'b01:   rsp_credit_cnt <= rsp_credit_cnt + 1'b1;
        default: rsp_credit_cnt <= rsp_credit_cnt;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (pop)
      cur <= head;
    if (div_done)
    begin
      div_rsp.result    <= div_pick;
      div_rsp.remainder <= remainder;
      div_rsp.zero      <= (div_pick == '0);
      div_rsp.negative  <= div_pick[31];
      div_rsp.borrow    <= 1'b0;
      div_rsp.tag       <= cur.tag;   // cur is held for the whole division
    end
  end

endmodule

//--- rtl/alu_pkg.sv
// Shared types and constants for the execute stage; the credit counts must fit in CNT_W bits
package alu_pkg;

  localparam int REQ_DEPTH   = 4;                  // Queue entries and initial producer credits
  localparam int RSP_CREDITS = 2;                  // Responses downstream can hold after reset
  localparam int CNT_W       = 3;                  // Holds 0..REQ_DEPTH
  localparam int PTR_W       = $clog2(REQ_DEPTH);  // Queue pointer width
  localparam int DIV_STEPS   = 32;                 // One quotient bit per step

  typedef logic [31:0] word_t;
  typedef logic [3:0]  tag_t;

  // Encodings are fixed by the ALU control interface
  typedef enum logic [4:0] {
    OP_AND    = 5'd0,
    OP_OR     = 5'd1,
    OP_ADD    = 5'd2,
    OP_XOR    = 5'd3,
    OP_SUB    = 5'd4,
    OP_NOT    = 5'd5,
    OP_SLL    = 5'd6,
    OP_SRL    = 5'd7,
    OP_SRA    = 5'd8,
    OP_SLT    = 5'd9,
    OP_SLTU   = 5'd10,
    OP_MUL    = 5'd11,   // Low half
    OP_MULH   = 5'd12,   // Signed x signed, high half
    OP_MULHSU = 5'd13,   // Signed x unsigned, high half
    OP_MULHU  = 5'd14,   // Unsigned x unsigned, high half
    OP_DIV    = 5'd15,
    OP_DIVU   = 5'd16,
    OP_REM    = 5'd17,
    OP_REMU   = 5'd18,
    OP_SUBU   = 5'd19    // Unsigned subtract with borrow out
  } alu_op_e;

  typedef struct packed {
    alu_op_e op;
    word_t   a;
    word_t   b;
    tag_t    tag;
  } alu_req_t;

  typedef struct packed {
    word_t result;
    word_t remainder;  // Divider remainder, zero for other ops
    logic  zero;
    logic  negative;
    logic  borrow;
    tag_t  tag;
  } alu_rsp_t;

endpackage

//--- rtl/alu_req_queue.sv
// Request FIFO that never refuses a push, so the producer must stay within its REQ_DEPTH credits
`timescale 1ns/1ps

module alu_req_queue import alu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid,
  input  alu_req_t req,
  input  logic     pop,
  output alu_req_t head,
  output logic     head_valid,
  output logic     req_credit
);

  alu_req_t             mem [REQ_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     count;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
    return (p == PTR_W'(REQ_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign head       = mem[rd_ptr];
  assign head_valid = (count != '0);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      req_credit <= 1'b0;
    end
    else
    begin
      if (req_valid)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      case ({req_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push and pop together
      endcase
      req_credit <= pop;           // One credit back per freed entry
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_valid)
      mem[wr_ptr] <= req;
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run with Verilator; the exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module alu_exec_tb \
  -f verilog.f -o alu_exec_sim &&
./obj_dir/alu_exec_sim ||
{ echo "Build or simulation returned an error status"; exit 1; }

//--- tb/alu_exec_props.sv
// Bound assertions on credit, reset and divider latency rules; probes the top level's counters
`timescale 1ns/1ps

module alu_exec_props import alu_pkg::*; (
  input logic             clk,
  input logic             rst_n,
  input logic             req_valid,
  input logic             req_credit,
  input logic             rsp_valid,
  input logic             div_start,
  input logic             div_done,
  input logic [CNT_W-1:0] queue_count,
  input logic [CNT_W-1:0] rsp_credit_cnt
);

  rsp_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> rsp_credit_cnt != '0)
    else $error("Response sent with no response credit left");

  no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid |-> queue_count < CNT_W'(REQ_DEPTH))
    else $error("Request pushed into a full queue");

  // Outputs settle one edge into reset
  quiet_in_reset: assert property (@(posedge clk)
    (!rst_n && $past(!rst_n)) |-> (!rsp_valid && !req_credit))
    else $error("Handshake output active during reset");

  done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
    div_done |-> $past(div_start, 33))
    else $error("Divider done without a start 33 cycles earlier");

  start_then_done: assert property (@(posedge clk) disable iff (!rst_n)
    $past(div_start, 33) |-> div_done)
    else $error("Divider did not finish 33 cycles after start");

endmodule

//--- tb/alu_exec_tb.sv
// Self-checking testbench for the execute stage; stops at the first mismatch, needs timing support
`timescale 1ns/1ps

module alu_exec_tb import alu_pkg::*; ();

  localparam int NUM_VEC = 27;
  localparam int IDX_W   = $clog2(NUM_VEC);

  typedef struct packed {
    alu_op_e op;
    word_t   a;
    word_t   b;
    word_t   result;
    word_t   rem;     // Expected remainder field
    logic    borrow;
  } vec_t;

  vec_t vectors [NUM_VEC] = '{
    '{OP_AND,    32'hF0F0_1234, 32'h0FF0_FF00, 32'h00F0_1200, 32'h0000_0000, 1'b0},
    '{OP_OR,     32'hF000_0000, 32'h0000_000F, 32'hF000_000F, 32'h0000_0000, 1'b0},
    '{OP_ADD,    32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_XOR,    32'hAAAA_5555, 32'hFFFF_0000, 32'h5555_5555, 32'h0000_0000, 1'b0},
    '{OP_SUB,    32'h0000_0005, 32'h0000_0007, 32'hFFFF_FFFE, 32'h0000_0000, 1'b0},
    '{OP_NOT,    32'h0000_FFFF, 32'h0000_0000, 32'hFFFF_0000, 32'h0000_0000, 1'b0},
    '{OP_SLL,    32'h0000_0001, 32'h0000_0024, 32'h0000_0010, 32'h0000_0000, 1'b0},  // Shamt 4
    '{OP_SRL,    32'h8000_0000, 32'h0000_001F, 32'h0000_0001, 32'h0000_0000, 1'b0},
    '{OP_SRA,    32'h8000_0000, 32'h0000_0004, 32'hF800_0000, 32'h0000_0000, 1'b0},
    '{OP_SLT,    32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001, 32'h0000_0000, 1'b0},
    '{OP_SLTU,   32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_MUL,    32'hFFFF_FFFE, 32'h0000_0003, 32'hFFFF_FFFA, 32'h0000_0000, 1'b0},
    '{OP_MULH,   32'hFFFF_FFFE, 32'h0000_0003, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0},
    '{OP_DIV,    32'hFFFF_FFF9, 32'h0000_0002, 32'hFFFF_FFFD, 32'hFFFF_FFFF, 1'b0},  // -7 / 2
    '{OP_MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0},
    '{OP_MULHU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE, 32'h0000_0000, 1'b0},
    '{OP_MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 32'h0000_0000, 1'b0},
    '{OP_DIVU,   32'h0000_0007, 32'h0000_0002, 32'h0000_0003, 32'h0000_0001, 1'b0},
    '{OP_REM,    32'hFFFF_FFF9, 32'h0000_0002, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0},
    '{OP_REMU,   32'h0000_0064, 32'h0000_0007, 32'h0000_0002, 32'h0000_0002, 1'b0},
    '{OP_DIV,    32'h0000_1234, 32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_1234, 1'b0},  // By zero
    '{OP_REMU,   32'hDEAD_BEEF, 32'h0000_0000, 32'hDEAD_BEEF, 32'hDEAD_BEEF, 1'b0},
    '{OP_REM,    32'hFFFF_FF00, 32'h0000_0000, 32'hFFFF_FF00, 32'hFFFF_FF00, 1'b0},
    '{OP_DIV,    32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 32'h0000_0000, 1'b0},  // Overflow
    '{OP_REM,    32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_SUBU,   32'h0000_0003, 32'h0000_0005, 32'hFFFF_FFFE, 32'h0000_0000, 1'b1},
    '{OP_SUBU,   32'h0000_0009, 32'h0000_0004, 32'h0000_0005, 32'h0000_0000, 1'b0}
  };

  logic       clk;
  logic       rst_n;
  logic       req_valid;
  alu_req_t   req;
  logic       req_credit;
  logic       rsp_valid;
  alu_rsp_t   rsp;
  logic       rsp_credit;
  int         expected_idx [$];  // Table indices in issue order
  int         credit_pulses;
  logic [7:0] lfsr;

  alu_exec_unit UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_credit (rsp_credit)
  );

  bind alu_exec_unit alu_exec_props u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid      (req_valid),
    .req_credit     (req_credit),
    .rsp_valid      (rsp_valid),
    .div_start      (div_start),
    .div_done       (div_done),
    .queue_count    (u_queue.count),
    .rsp_credit_cnt (u_issue.rsp_credit_cnt)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Taps 8, 6, 5, 4
  function automatic logic [7:0] lfsr_next(logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  // Full 64-bit product of sign or zero extended operands
  function automatic word_t product_ref(alu_op_e op, word_t a, word_t b);
    logic [63:0] p;
    case (op)
      OP_MULHSU: p = {{32{a[31]}}, a} * {32'b0, b};
      OP_MULHU:  p = {32'b0, a} * {32'b0, b};
      default:   p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    endcase
    return (op == OP_MUL) ? p[31:0] : p[63:32];
  endfunction

  task automatic abort_run(string why);
    $display("Test failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(string name, word_t got, word_t want);
    if (got !== want)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, want);
      abort_run("A checked value did not match its expected value");
    end
  endtask

  // Sends the table while credits last, then collects the remaining credits
  task automatic produce();
    int   sent;
    int   credits;
    vec_t v;
    sent    = 0;
    credits = REQ_DEPTH;
    while (sent < NUM_VEC || credits < REQ_DEPTH)
    begin
      @(posedge clk);
      if (req_credit)
      begin
        credits++;
        credit_pulses++;
      end
      if (sent < NUM_VEC && credits > 0)
      begin
        v = vectors[IDX_W'(sent)];
        req_valid <= 1'b1;
        req       <= '{op: v.op, a: v.a, b: v.b, tag: tag_t'(sent)};
        expected_idx.push_back(sent);
        credits--;
        sent++;
      end
      else
        req_valid <= 1'b0;
    end
  endtask

  task automatic consume();
    int   received;
    int   cycle;
    int   idx;
    int   delay;
    int   due [$];  // Cycles at which credits go back
    vec_t v;
    received = 0;
    cycle    = 0;
    while (received < NUM_VEC || due.size() > 0)
    begin
      @(posedge clk);
      cycle++;
      if (rsp_valid)
      begin
        if (expected_idx.size() == 0)
          abort_run("A response arrived with no request outstanding");
        idx = expected_idx.pop_front();
        v   = vectors[IDX_W'(idx)];
        check_value("rsp.tag", 32'(rsp.tag), 32'(tag_t'(idx)));
        check_value("rsp.result", rsp.result, v.result);
        check_value("rsp.remainder", rsp.remainder, v.rem);
        check_value("rsp.zero", 32'(rsp.zero), 32'(v.result == '0));
        check_value("rsp.negative", 32'(rsp.negative), 32'(v.result[31]));
        check_value("rsp.borrow", 32'(rsp.borrow), 32'(v.borrow));
        if (v.op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU})
          check_value("rsp.result vs product", rsp.result, product_ref(v.op, v.a, v.b));
        delay = 0;
        repeat (3)
        begin
          lfsr  = lfsr_next(lfsr);
          delay = (delay << 1) | 32'(lfsr[0]);  // 0 to 7 cycles
        end
        due.push_back(cycle + delay);
        received++;
      end
      if (due.size() > 0 && due[0] <= cycle)
      begin
        rsp_credit <= 1'b1;
        void'(due.pop_front());
      end
      else
        rsp_credit <= 1'b0;
    end
    @(posedge clk);
    rsp_credit <= 1'b0;
  endtask

  initial
  begin
    rst_n      <= 1'b0;
    req_valid  <= 1'b0;
    req        <= '0;
    rsp_credit <= 1'b0;
    credit_pulses = 0;
    lfsr          = 8'd5;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    fork
      produce();
      consume();
    join
    repeat (40)  // Quiet window longer than a division
    begin
      @(posedge clk);
      if (rsp_valid || req_credit)
        abort_run("An extra response or credit appeared after the last request");
    end
    check_value("req_credit pulses", credit_pulses, NUM_VEC);
    $display("Test passed");
    $finish;
  end

  initial
  begin
    #(NUM_VEC * 40 * 8 + 1000);
    abort_run("Watchdog expired before all responses arrived");
  end

endmodule

//--- verilog.f
rtl/alu_pkg.sv
rtl/alu_req_queue.sv
rtl/alu_core.sv
rtl/alu_divider.sv
rtl/alu_issue.sv
rtl/alu_exec_unit.sv
tb/alu_exec_props.sv
tb/alu_exec_tb.sv
